//--- hdl/pix_pkg.sv
package pix_pkg;

    ////////////////////
    // Frame geometry
    ////////////////////

    // Pixels per row and rows per frame
    localparam int IMG_COLS = 8;
    localparam int IMG_ROWS = 6;
    localparam int FRAME_PIXELS = IMG_COLS * IMG_ROWS;
    // Four pixels pack into three words
    localparam int FRAME_WORDS = (FRAME_PIXELS * 3) / 4;

    ////////////////////
    // Widths
    ////////////////////

    localparam int WORD_W = 32;
    localparam int PIX_W = 24;
    localparam int ADDR_W = 6;

    // Packed memory word, byte 0 in bits 7:0
    typedef logic [WORD_W-1:0] word_t;
    // One RGB pixel, R in bits 7:0
    typedef logic [PIX_W-1:0] pixel_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [2:0] col_t;
    typedef logic [2:0] row_t;

    // Fetch controller states
    typedef enum logic {IDLE, READ} fetch_state_t;
    // Byte alignment of the unpacker, PH3 is the gap cycle
    typedef enum logic [1:0] {PH0, PH1, PH2, PH3} unpack_phase_t;

endpackage

//--- hdl/frame_word_ram.sv
`timescale 1ns/1ps

module frame_word_ram (
    input  logic           clk,
    input  logic           rst,
    // Host write port
    input  logic           wr_en,
    input  pix_pkg::addr_t wr_addr,
    input  pix_pkg::word_t wr_data,
    // Read port, one cycle latency
    input  logic           rd_en,
    input  pix_pkg::addr_t rd_addr,
    output pix_pkg::word_t rd_data,
    output logic           rd_valid
);

    // One packed frame
    pix_pkg::word_t mem [pix_pkg::FRAME_WORDS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        // Registered read data
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // Valid follows the read enable by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    // Fetch must stay inside the frame
    a_rd_in_range: assert property (@(posedge clk) disable iff (rst)
        rd_en |-> (int'(rd_addr) < pix_pkg::FRAME_WORDS));

endmodule

//--- hdl/frame_word_fetch.sv
`timescale 1ns/1ps

module frame_word_fetch (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    // Gap request from the unpacker
    input  logic           stall,
    output logic           busy,
    output logic           rd_en,
    output pix_pkg::addr_t rd_addr
);

    pix_pkg::fetch_state_t state_q;
    pix_pkg::addr_t        addr_q;
    logic                  last_word;

    ////////////////////
    // Read issue
    ////////////////////

    // Hold off reads while the unpacker drains its cache
    assign rd_en = (state_q == pix_pkg::READ) && !stall;
    assign rd_addr = addr_q;
    assign busy = (state_q == pix_pkg::READ);

    // Word FRAME_WORDS-1 issued this cycle
    assign last_word = rd_en && (addr_q == pix_pkg::addr_t'(pix_pkg::FRAME_WORDS - 1));

    ////////////////////
    // State machine
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= pix_pkg::IDLE;
            addr_q <= '0;
        end else begin
            case (state_q)
                pix_pkg::IDLE: begin
                    // Start only counts when idle
                    if (start) begin
                        state_q <= pix_pkg::READ;
                        addr_q <= '0;
                    end
                end
                pix_pkg::READ: begin
                    if (rd_en) begin
                        addr_q <= addr_q + 1'b1;
                    end
                    // Done once the last word is out
                    if (last_word) begin
                        state_q <= pix_pkg::IDLE;
                    end
                end
                default: begin
                    state_q <= pix_pkg::IDLE;
                end
            endcase
        end
    end

    // A gap lasts one cycle, reads resume right after it
    a_gap_one_cycle: assert property (@(posedge clk) disable iff (rst)
        stall |=> (rd_en || !busy));

endmodule

//--- hdl/pixel_unpack.sv
`timescale 1ns/1ps

module pixel_unpack (
    input  logic            clk,
    input  logic            rst,
    // Word stream from the ram
    input  pix_pkg::word_t  word,
    input  logic            word_valid,
    // Pixel stream, no latency
    output pix_pkg::pixel_t pixel,
    output logic            pixel_valid,
    // Asks fetch for a gap
    output logic            stall
);

    pix_pkg::unpack_phase_t phase_q;
    pix_pkg::unpack_phase_t phase_nxt;
    // Upper three bytes of the previous word
    pix_pkg::pixel_t        spare_q;

    ////////////////////
    // Spare byte cache
    ////////////////////

    always_ff @(posedge clk) begin
        if (word_valid) begin
            spare_q <= word[31:8];
        end
    end

    ////////////////////
    // Phase tracking
    ////////////////////

    always_comb begin
        case (phase_q)
            pix_pkg::PH0: phase_nxt = pix_pkg::PH1;
            pix_pkg::PH1: phase_nxt = pix_pkg::PH2;
            pix_pkg::PH2: phase_nxt = pix_pkg::PH3;
            default:      phase_nxt = pix_pkg::PH0;
        endcase
    end

    // PH3 moves on by itself, the others wait for a word
    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q <= pix_pkg::PH0;
        end else if (word_valid || phase_q == pix_pkg::PH3) begin
            phase_q <= phase_nxt;
        end
    end

    ////////////////////
    // Pixel select
    ////////////////////

    always_comb begin
        case (phase_q)
            // Bytes 0..2 of this word
            pix_pkg::PH0: pixel = word[23:0];
            // Cached byte 3, then bytes 0..1
            pix_pkg::PH1: pixel = {word[15:0], spare_q[23:16]};
            // Cached bytes 2..3, then byte 0
            pix_pkg::PH2: pixel = {word[7:0], spare_q[23:8]};
            // Gap cycle, cached bytes 1..3 only
            default:      pixel = spare_q;
        endcase
    end

    assign pixel_valid = word_valid || (phase_q == pix_pkg::PH3);
    // Third word of a group just landed
    assign stall = (phase_q == pix_pkg::PH2) && word_valid;

    // Fetch must have honoured the stall one cycle earlier
    a_no_word_in_gap: assert property (@(posedge clk) disable iff (rst)
        (phase_q == pix_pkg::PH3) |-> !word_valid);

endmodule

//--- hdl/pixel_frame_tagger.sv
`timescale 1ns/1ps

module pixel_frame_tagger (
    input  logic            clk,
    input  logic            rst,
    input  pix_pkg::pixel_t pixel,
    input  logic            pixel_valid,
    output logic            pix_valid,
    output pix_pkg::pixel_t pix_data,
    output pix_pkg::col_t   pix_col,
    output pix_pkg::row_t   pix_row,
    output logic            pix_last_col,
    output logic            pix_last_frame
);

    pix_pkg::col_t col_q;
    pix_pkg::row_t row_q;
    logic          col_end;
    logic          row_end;

    assign col_end = (col_q == pix_pkg::col_t'(pix_pkg::IMG_COLS - 1));
    assign row_end = (row_q == pix_pkg::row_t'(pix_pkg::IMG_ROWS - 1));

    ////////////////////
    // Position counters
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            col_q <= '0;
            row_q <= '0;
        end else if (pixel_valid) begin
            col_q <= col_end ? '0 : col_q + 1'b1;
            // Row bumps on column wrap, wraps at frame end
            if (col_end) begin
                row_q <= row_end ? '0 : row_q + 1'b1;
            end
        end
    end

    ////////////////////
    // Output register
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pix_valid <= 1'b0;
            pix_col <= '0;
            pix_row <= '0;
            pix_last_col <= 1'b0;
            pix_last_frame <= 1'b0;
        end else begin
            pix_valid <= pixel_valid;
            pix_col <= col_q;
            pix_row <= row_q;
            // Flags only with a valid pixel
            pix_last_col <= pixel_valid && col_end;
            pix_last_frame <= pixel_valid && col_end && row_end;
        end
    end

    // Pixel payload
    always_ff @(posedge clk) begin
        if (pixel_valid) begin
            pix_data <= pixel;
        end
    end

endmodule

//--- hdl/pixel_frontend_top.sv
`timescale 1ns/1ps

module pixel_frontend_top (
    input  logic            clk,
    input  logic            rst,
    // Host memory write
    input  logic            wr_en,
    input  pix_pkg::addr_t  wr_addr,
    input  pix_pkg::word_t  wr_data,
    // Frame control
    input  logic            start,
    output logic            busy,
    // Tagged pixel stream
    output logic            pix_valid,
    output pix_pkg::pixel_t pix_data,
    output pix_pkg::col_t   pix_col,
    output pix_pkg::row_t   pix_row,
    output logic            pix_last_col,
    output logic            pix_last_frame
);

    // Read path
    logic            rd_en;
    pix_pkg::addr_t  rd_addr;
    pix_pkg::word_t  rd_data;
    logic            rd_valid;
    // Gap request back to fetch
    logic            stall;
    // Untagged pixels
    pix_pkg::pixel_t pixel;
    logic            pixel_valid;

    ////////////////////
    // Memory and fetch
    ////////////////////

    frame_word_ram ram_i (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

    frame_word_fetch fetch_i (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .stall   (stall),
        .busy    (busy),
        .rd_en   (rd_en),
        .rd_addr (rd_addr)
    );

    ////////////////////
    // Unpack and tag
    ////////////////////

    pixel_unpack unpack_i (
        .clk         (clk),
        .rst         (rst),
        .word        (rd_data),
        .word_valid  (rd_valid),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .stall       (stall)
    );

    pixel_frame_tagger tagger_i (
        .clk            (clk),
        .rst            (rst),
        .pixel          (pixel),
        .pixel_valid    (pixel_valid),
        .pix_valid      (pix_valid),
        .pix_data       (pix_data),
        .pix_col        (pix_col),
        .pix_row        (pix_row),
        .pix_last_col   (pix_last_col),
        .pix_last_frame (pix_last_frame)
    );

endmodule

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk
);

    // Half of the 4 ns period
    localparam int HALF_NS = 2;

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_NS) clk = ~clk;
        end
    end

endmodule

//--- tb/tb_pixel_frontend.sv
`timescale 1ns/1ps

module tb_pixel_frontend;

    localparam int MODEL_BYTES = pix_pkg::FRAME_WORDS * 4;
    // Start cycle to first pixel
    localparam int FIRST_LAG = 3;
    // Three reads and one gap per group
    localparam int READ_CYCLES = (pix_pkg::FRAME_WORDS / 3) * 4;
    localparam int FRAME_END = FIRST_LAG + pix_pkg::FRAME_PIXELS;
    // Two fills of 36 writes, two frames of ~55 cycles, margin
    localparam int CYCLE_LIMIT = 400;
    localparam int BUSY_POKE = 20;

    logic            clk;
    logic            rst;
    logic            wr_en;
    pix_pkg::addr_t  wr_addr;
    pix_pkg::word_t  wr_data;
    logic            start;
    logic            busy;
    logic            pix_valid;
    pix_pkg::pixel_t pix_data;
    pix_pkg::col_t   pix_col;
    pix_pkg::row_t   pix_row;
    logic            pix_last_col;
    logic            pix_last_frame;

    // Byte stream of the frame, byte 0 first
    logic [7:0]      model [MODEL_BYTES];
    integer          seed;
    // Frame tracking
    logic            frame_begin;
    logic            frame_on_q;
    int              since_q;
    int              k_q;
    int              k_idx;
    int              cycle_q;
    // Expected outputs
    logic            exp_valid;
    logic            exp_busy;
    pix_pkg::pixel_t exp_pix;
    pix_pkg::col_t   exp_col;
    pix_pkg::row_t   exp_row;
    logic            exp_last_col;
    logic            exp_last_frame;

    tb_clk_gen clk_gen_i (.clk(clk));

    pixel_frontend_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .start          (start),
        .busy           (busy),
        .pix_valid      (pix_valid),
        .pix_data       (pix_data),
        .pix_col        (pix_col),
        .pix_row        (pix_row),
        .pix_last_col   (pix_last_col),
        .pix_last_frame (pix_last_frame)
    );

    ////////////////////
    // Reference model
    ////////////////////

    // Cycle count since start, pixel index k
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_on_q <= 1'b0;
            since_q <= 0;
            k_q <= 0;
        end else if (frame_begin) begin
            frame_on_q <= 1'b1;
            since_q <= 1;
            k_q <= 0;
        end else if (frame_on_q) begin
            since_q <= since_q + 1;
            if (exp_valid) begin
                k_q <= k_q + 1;
            end
            if (since_q == FRAME_END) begin
                frame_on_q <= 1'b0;
            end
        end
    end

    // 48 back to back pixels, busy only while reads remain
    assign exp_valid = frame_on_q && since_q >= FIRST_LAG && since_q < FRAME_END;
    assign exp_busy = frame_on_q && since_q < READ_CYCLES;
    // Pixel k is bytes 3k..3k+2
    assign k_idx = k_q % pix_pkg::FRAME_PIXELS;
    assign exp_pix = {model[3*k_idx+2], model[3*k_idx+1], model[3*k_idx]};
    assign exp_col = pix_pkg::col_t'(k_q % pix_pkg::IMG_COLS);
    assign exp_row = pix_pkg::row_t'(k_q / pix_pkg::IMG_COLS);
    assign exp_last_col = exp_valid && (k_q % pix_pkg::IMG_COLS == pix_pkg::IMG_COLS - 1);
    assign exp_last_frame = exp_valid && (k_q == pix_pkg::FRAME_PIXELS - 1);

    ////////////////////
    // Checks
    ////////////////////

    task automatic stop_failed();
        $display("TB FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_value(input string name, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
        $display("ERR t=%0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
        stop_failed();
    endtask

    a_busy: assert property (@(posedge clk) disable iff (rst) busy == exp_busy)
        else report_value("busy", 32'($sampled(exp_busy)), 32'($sampled(busy)));
    a_valid: assert property (@(posedge clk) disable iff (rst) pix_valid == exp_valid)
        else report_value("pix_valid", 32'($sampled(exp_valid)), 32'($sampled(pix_valid)));
    a_data: assert property (@(posedge clk) disable iff (rst) pix_valid |-> pix_data == exp_pix)
        else report_value("pix_data", 32'($sampled(exp_pix)), 32'($sampled(pix_data)));
    a_col: assert property (@(posedge clk) disable iff (rst) pix_valid |-> pix_col == exp_col)
        else report_value("pix_col", 32'($sampled(exp_col)), 32'($sampled(pix_col)));
    a_row: assert property (@(posedge clk) disable iff (rst) pix_valid |-> pix_row == exp_row)
        else report_value("pix_row", 32'($sampled(exp_row)), 32'($sampled(pix_row)));
    a_last_col: assert property (@(posedge clk) disable iff (rst) pix_last_col == exp_last_col)
        else report_value("pix_last_col", 32'($sampled(exp_last_col)),
                          32'($sampled(pix_last_col)));
    a_last_frame: assert property (@(posedge clk) disable iff (rst)
        pix_last_frame == exp_last_frame)
        else report_value("pix_last_frame", 32'($sampled(exp_last_frame)),
                          32'($sampled(pix_last_frame)));

    // Run limit
    always @(posedge clk) begin
        cycle_q <= cycle_q + 1;
        if (cycle_q == CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, frames did not complete", CYCLE_LIMIT);
            stop_failed();
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    // New random bytes, packed four to a word
    task automatic fill_memory();
        for (int b = 0; b < MODEL_BYTES; b++) begin
            model[b] = 8'($random(seed));
        end
        for (int w = 0; w < pix_pkg::FRAME_WORDS; w++) begin
            @(posedge clk);
            wr_en <= 1'b1;
            wr_addr <= pix_pkg::addr_t'(w);
            wr_data <= {model[4*w+3], model[4*w+2], model[4*w+1], model[4*w]};
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic run_frame(input logic poke_busy);
        fill_memory();
        @(posedge clk);
        start <= 1'b1;
        frame_begin <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        frame_begin <= 1'b0;
        // Stray start mid frame, must be ignored
        if (poke_busy) begin
            repeat (BUSY_POKE) @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
        end
        @(posedge clk);
        while (frame_on_q) begin
            @(posedge clk);
        end
    endtask

    initial begin
        seed = 32'h32c44cbe;
        rst = 1'b1;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        start = 1'b0;
        frame_begin = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        run_frame(1'b1);
        // Rewrite and run again from a clean phase
        run_frame(1'b0);
        repeat (2) @(posedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- all.f
hdl/pix_pkg.sv
hdl/frame_word_ram.sv
hdl/frame_word_fetch.sv
hdl/pixel_unpack.sv
hdl/pixel_frame_tagger.sv
hdl/pixel_frontend_top.sv
tb/tb_clk_gen.sv
tb/tb_pixel_frontend.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the pixel front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module tb_pixel_frontend -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -q "TB PASSED"
